// ==== aes_pkg.sv ====
/*
 * shared constants and helper functions for the AES-128 encryption core
 * byte order follows FIPS-197 so block byte 0 sits in bits 127:120
 * register offsets are 12-bit byte addresses on a word-aligned APB map
 * only the forward S-box is provided since the core never decrypts
 */
package aes_pkg;

    localparam int block_w    = 128; // block and key width
    localparam int num_rounds = 10;  // AES-128 round count
    localparam int round_w    = 4;   // wide enough to count to num_rounds

    // register map, each block register spans four consecutive words
    localparam logic [11:0] reg_ctrl   = 12'h000;
    localparam logic [11:0] reg_status = 12'h004;
    localparam logic [11:0] reg_key0   = 12'h010;
    localparam logic [11:0] reg_din0   = 12'h020;
    localparam logic [11:0] reg_dout0  = 12'h030;

    // forward S-box with entry 0 in the top byte so the index reads naturally
    localparam logic [0:255][7:0] sbox_tbl = {
        128'h637c777bf26b6fc53001672bfed7ab76,
        128'hca82c97dfa5947f0add4a2af9ca472c0,
        128'hb7fd9326363ff7cc34a5e5f171d83115,
        128'h04c723c31896059a071280e2eb27b275,
        128'h09832c1a1b6e5aa0523bd6b329e32f84,
        128'h53d100ed20fcb15b6acbbe394a4c58cf,
        128'hd0efaafb434d338545f9027f503c9fa8,
        128'h51a3408f929d38f5bcb6da2110fff3d2,
        128'hcd0c13ec5f974417c4a77e3d645d1973,
        128'h60814fdc222a908846eeb814de5e0bdb,
        128'he0323a0a4906245cc2d3ac629195e479,
        128'he7c8376d8dd54ea96c56f4ea657aae08,
        128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
        128'h703eb5664803f60e613557b986c11d9e,
        128'he1f8981169d98e949b1e87e9ce5528df,
        128'h8ca1890dbfe6426841992d0fb054bb16
    };

    // plain table lookup so synthesis builds a 256 x 8 ROM per use
    function automatic logic [7:0] sbox(input logic [7:0] b);
        return sbox_tbl[b];
    endfunction

    // multiply by x in GF(2^8) modulo the AES polynomial 0x11b
    function automatic logic [7:0] xtime(input logic [7:0] b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    // round constant for the key schedule, rounds outside 1 to 10 give zero
    function automatic logic [7:0] rcon(input logic [round_w-1:0] r);
        logic [7:0] c;
        case (r)
            4'd1:    c = 8'h01;
            4'd2:    c = 8'h02;
            4'd3:    c = 8'h04;
            4'd4:    c = 8'h08;
            4'd5:    c = 8'h10;
            4'd6:    c = 8'h20;
            4'd7:    c = 8'h40;
            4'd8:    c = 8'h80;
            4'd9:    c = 8'h1b; // reduction kicks in after 0x80
            4'd10:   c = 8'h36;
            default: c = 8'h00;
        endcase
        return c;
    endfunction

endpackage

// ==== aes_key_expand.sv ====
/*
 * on-the-fly AES-128 key schedule, no table of eleven round keys is kept
 * the register holds the previous round key and round_key is the next one,
 * computed combinationally with the round constant of the round input
 * key_load has priority over key_step
 */
`timescale 1ns/1ps

module aes_key_expand
    import aes_pkg::*;
(
    input  logic               clk,
    input  logic               resetn,
    input  logic               key_load,  // take the cipher key
    input  logic               key_step,  // advance to the next round key
    input  logic [block_w-1:0] key,
    input  logic [round_w-1:0] round,     // selects rcon for the key being produced
    output logic [block_w-1:0] round_key
);

    logic [block_w-1:0] key_q; // round key of the previous round
    logic [31:0]        w0, w1, w2, w3;
    logic [31:0]        rot_word;
    logic [31:0]        sub_word;
    logic [31:0]        temp;
    logic [31:0]        n0, n1, n2, n3;

    assign {w0, w1, w2, w3} = key_q; // w0 is the word at the lowest byte address

    // RotWord moves the top byte of the last word down to the bottom
    assign rot_word = {w3[23:0], w3[31:24]};

    // SubWord runs each byte through the S-box
    assign sub_word = {sbox(rot_word[31:24]), sbox(rot_word[23:16]),
                       sbox(rot_word[15:8]),  sbox(rot_word[7:0])};

    assign temp = sub_word ^ {rcon(round), 24'h000000}; // rcon only touches the top byte

    // each new word chains off the one just produced
    assign n0 = w0 ^ temp;
    assign n1 = w1 ^ n0;
    assign n2 = w2 ^ n1;
    assign n3 = w3 ^ n2;

    assign round_key = {n0, n1, n2, n3};

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            key_q <= '0;
        end
        else if (key_load)
        begin
            key_q <= key;
        end
        else if (key_step)
        begin
            key_q <= round_key; // the key used this round becomes the base of the next
        end
    end

endmodule

// ==== aes_round_func.sv ====
/*
 * one AES encryption round without the AddRoundKey step, purely combinational
 * state bytes are column-major, byte 4*c+r is row r of column c
 * MixColumns is bypassed when last_round is high
 */
`timescale 1ns/1ps

module aes_round_func
    import aes_pkg::*;
(
    input  logic [block_w-1:0] state_in,
    input  logic               last_round, // skip MixColumns in round ten
    output logic [block_w-1:0] state_out
);

    logic [7:0] sub_bytes  [16];
    logic [7:0] shift_rows [16];
    logic [7:0] mix_cols   [16];

    // SubBytes on all sixteen bytes, byte 0 taken from the top of the block
    always_comb
    begin
        for (int i = 0; i < 16; i++)
        begin
            sub_bytes[i] = sbox(state_in[block_w-1-8*i -: 8]);
        end
    end

    // row r rotates left by r columns
    always_comb
    begin
        for (int c = 0; c < 4; c++)
        begin
            for (int r = 0; r < 4; r++)
            begin
                shift_rows[4*c+r] = sub_bytes[4*((c+r)%4)+r];
            end
        end
    end

    // MixColumns with the fixed matrix 2 3 1 1, where 3a is xtime(a) ^ a
    always_comb
    begin
        logic [7:0] a0, a1, a2, a3;
        for (int c = 0; c < 4; c++)
        begin
            a0 = shift_rows[4*c];
            a1 = shift_rows[4*c+1];
            a2 = shift_rows[4*c+2];
            a3 = shift_rows[4*c+3];
            mix_cols[4*c]   = xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3;
            mix_cols[4*c+1] = a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3;
            mix_cols[4*c+2] = a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3;
            mix_cols[4*c+3] = xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3);
        end
    end

    // pack back into the FIPS-197 bit order
    always_comb
    begin
        for (int i = 0; i < 16; i++)
        begin
            state_out[block_w-1-8*i -: 8] = last_round ? shift_rows[i] : mix_cols[i];
        end
    end

endmodule

// ==== aes_add_round_key.sv ====
/*
 * registered AddRoundKey stage, this register is the cipher state itself
 * out_valid follows in_valid by one cycle
 * data_out holds its value while in_valid is low
 */
`timescale 1ns/1ps

module aes_add_round_key
    import aes_pkg::*;
(
    input  logic               clk,
    input  logic               resetn,
    input  logic               in_valid,
    input  logic [block_w-1:0] data_in,  // plaintext or round function output
    input  logic [block_w-1:0] key_in,   // round key for this step
    output logic [block_w-1:0] data_out, // current cipher state
    output logic               out_valid
);

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            data_out  <= '0;
            out_valid <= 1'b0;
        end
        else
        begin
            out_valid <= in_valid; // one cycle marker for each registered result
            if (in_valid)
            begin
                data_out <= data_in ^ key_in;
            end
        end
    end

endmodule

// ==== aes_core.sv ====
/*
 * iterative AES-128 encryption, one state update per clock
 * start is ignored while busy, only one block is in flight at a time
 * done pulses eleven cycles after start and ciphertext is valid with it
 * key and plaintext must stay stable during the start cycle only
 */
`timescale 1ns/1ps

module aes_core
    import aes_pkg::*;
(
    input  logic               clk,
    input  logic               resetn,
    input  logic               start,      // one cycle request from the register block
    input  logic [block_w-1:0] key,
    input  logic [block_w-1:0] plaintext,
    output logic               busy,
    output logic               done,       // one cycle pulse
    output logic [block_w-1:0] ciphertext
);

    logic [round_w-1:0] round;     // zero when no round is running
    logic               accept;
    logic               key_load;
    logic               key_step;
    logic               last_round;
    logic               in_valid;
    logic               out_valid;
    logic [block_w-1:0] round_key;
    logic [block_w-1:0] round_out;
    logic [block_w-1:0] ark_data;
    logic [block_w-1:0] ark_key;
    logic [block_w-1:0] state;

    assign accept     = start & ~busy;
    assign key_load   = accept;
    assign key_step   = (round != '0);             // one key step per round
    assign last_round = (round == round_w'(num_rounds));
    assign in_valid   = accept | key_step;

    // the initial AddRoundKey uses the cipher key straight from the input
    assign ark_data = accept ? plaintext : round_out;
    assign ark_key  = accept ? key : round_key;

    // round ten has registered once the counter is back at zero with busy still set
    assign done       = out_valid & busy & (round == '0);
    assign ciphertext = state;

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            busy  <= 1'b0;
            round <= '0;
        end
        else
        begin
            if (accept)
            begin
                busy  <= 1'b1;
                round <= round_w'(1);
            end
            else if (key_step)
            begin
                round <= last_round ? '0 : round + 1'b1;
            end
            if (done)
                busy <= 1'b0; // stays up for the done cycle so the pulse is qualified
        end
    end

    aes_key_expand u_key_expand (
        .clk       (clk),
        .resetn    (resetn),
        .key_load  (key_load),
        .key_step  (key_step),
        .key       (key),
        .round     (round),
        .round_key (round_key)
    );

    aes_round_func u_round_func (
        .state_in   (state),
        .last_round (last_round),
        .state_out  (round_out)
    );

    aes_add_round_key u_add_round_key (
        .clk       (clk),
        .resetn    (resetn),
        .in_valid  (in_valid),
        .data_in   (ark_data),
        .key_in    (ark_key),
        .data_out  (state),
        .out_valid (out_valid)
    );

endmodule

// ==== aes_apb_regs.sv ====
/*
 * APB slave register block for the AES core, no wait states and no slave error
 * accesses are 32-bit words, paddr[1:0] is not decoded
 * writes to KEY and DIN and start requests are dropped while the core is busy
 * DOUT is read-only and unmapped offsets read as zero
 */
`timescale 1ns/1ps

module aes_apb_regs
    import aes_pkg::*;
(
    input  logic               clk,
    input  logic               resetn,
    input  logic [11:0]        paddr,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  logic [31:0]        pwdata,
    input  logic               busy,       // from the core
    input  logic               done,       // one cycle pulse from the core
    input  logic [block_w-1:0] ciphertext,
    output logic [31:0]        prdata,
    output logic               pready,
    output logic               start,      // one cycle pulse to the core
    output logic [block_w-1:0] key,
    output logic [block_w-1:0] plaintext
);

    logic               wr_en;
    logic               rd_en;
    logic               core_active; // busy or a start still on its way to the core
    logic [1:0]         word;        // word within a 128-bit register
    logic               sel_key;
    logic               sel_din;
    logic               sel_dout;
    logic [block_w-1:0] dout;
    logic               done_q;      // sticky done bit of STATUS

    assign pready = 1'b1;

    // a write or read takes effect in the access phase
    assign wr_en = psel & penable & pwrite;
    assign rd_en = psel & penable & ~pwrite;

    assign core_active = busy | start;

    assign word     = paddr[3:2];
    assign sel_key  = (paddr[11:4] == reg_key0[11:4]);
    assign sel_din  = (paddr[11:4] == reg_din0[11:4]);
    assign sel_dout = (paddr[11:4] == reg_dout0[11:4]);

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            start     <= 1'b0;
            done_q    <= 1'b0;
            key       <= '0;
            plaintext <= '0;
            dout      <= '0;
        end
        else
        begin
            start <= 1'b0;
            if (wr_en && !core_active)
            begin
                // word 0 of each block register carries bytes 0 to 3
                if (sel_key)
                    key[block_w-1-32*word -: 32] <= pwdata;
                if (sel_din)
                    plaintext[block_w-1-32*word -: 32] <= pwdata;
                if (paddr == reg_ctrl && pwdata[0])
                begin
                    start  <= 1'b1;
                    done_q <= 1'b0; // a new block clears the old result flag
                end
            end
            // done only arrives while busy, so it never meets an accepted start
            if (done)
            begin
                dout   <= ciphertext;
                done_q <= 1'b1;
            end
        end
    end

    // read mux, CTRL and every unmapped offset return zero
    always_comb
    begin
        prdata = '0;
        if (rd_en)
        begin
            if (paddr == reg_status)
                prdata = {30'd0, done_q, core_active};
            else if (sel_key)
                prdata = key[block_w-1-32*word -: 32];
            else if (sel_din)
                prdata = plaintext[block_w-1-32*word -: 32];
            else if (sel_dout)
                prdata = dout[block_w-1-32*word -: 32];
        end
    end

endmodule

// ==== aes_top.sv ====
/*
 * AES-128 encryption core with an APB register interface
 * pready is tied high so every transfer is one setup and one access cycle
 * see aes_pkg for the register offsets
 */
`timescale 1ns/1ps

module aes_top
    import aes_pkg::*;
(
    input  logic        clk,
    input  logic        resetn,
    input  logic [11:0] paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready
);

    logic               start;      // register block to core
    logic               busy;
    logic               done;
    logic [block_w-1:0] key;
    logic [block_w-1:0] plaintext;
    logic [block_w-1:0] ciphertext; // copied into DOUT on done

    aes_apb_regs u_regs (
        .clk        (clk),
        .resetn     (resetn),
        .paddr      (paddr),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .pwdata     (pwdata),
        .busy       (busy),
        .done       (done),
        .ciphertext (ciphertext),
        .prdata     (prdata),
        .pready     (pready),
        .start      (start),
        .key        (key),
        .plaintext  (plaintext)
    );

    aes_core u_core (
        .clk        (clk),
        .resetn     (resetn),
        .start      (start),
        .key        (key),
        .plaintext  (plaintext),
        .busy       (busy),
        .done       (done),
        .ciphertext (ciphertext)
    );

endmodule

// ==== tb_aes_model.svh ====
/*
 * reference AES-128 encryption for the testbench, byte level as in FIPS-197
 * carries its own S-box table so it does not share any logic with the DUT
 * also holds the LCG step used for random keys and plaintexts
 */
`ifndef TB_AES_MODEL_SVH
`define TB_AES_MODEL_SVH

// forward S-box, entry 0 in the top byte
localparam logic [0:255][7:0] ref_sbox = {
    128'h637c777bf26b6fc53001672bfed7ab76,
    128'hca82c97dfa5947f0add4a2af9ca472c0,
    128'hb7fd9326363ff7cc34a5e5f171d83115,
    128'h04c723c31896059a071280e2eb27b275,
    128'h09832c1a1b6e5aa0523bd6b329e32f84,
    128'h53d100ed20fcb15b6acbbe394a4c58cf,
    128'hd0efaafb434d338545f9027f503c9fa8,
    128'h51a3408f929d38f5bcb6da2110fff3d2,
    128'hcd0c13ec5f974417c4a77e3d645d1973,
    128'h60814fdc222a908846eeb814de5e0bdb,
    128'he0323a0a4906245cc2d3ac629195e479,
    128'he7c8376d8dd54ea96c56f4ea657aae08,
    128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
    128'h703eb5664803f60e613557b986c11d9e,
    128'he1f8981169d98e949b1e87e9ce5528df,
    128'h8ca1890dbfe6426841992d0fb054bb16
};

// one step of a 32-bit LCG with the common multiplier and increment
function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
endfunction

// doubling in GF(2^8), reduced by the AES polynomial
function automatic logic [7:0] gf_double(input logic [7:0] b);
    return (b << 1) ^ (b[7] ? 8'h1b : 8'h00);
endfunction

function automatic logic [127:0] aes128_encrypt(input logic [127:0] key,
                                                input logic [127:0] pt);
    logic [7:0]   st  [16]; // state, byte 4*c+r is row r of column c
    logic [7:0]   tmp [16];
    logic [7:0]   rk  [16]; // current round key in the same byte order
    logic [7:0]   rc;
    logic [127:0] ct;
    rc = 8'h01;
    for (int i = 0; i < 16; i++)
    begin
        rk[i] = key[127-8*i -: 8];
        st[i] = pt[127-8*i -: 8] ^ rk[i]; // initial AddRoundKey
    end
    for (int rnd = 1; rnd <= 10; rnd++)
    begin
        // first word takes RotWord and SubWord of the last word plus rcon
        rk[0] = rk[0] ^ ref_sbox[rk[13]] ^ rc;
        rk[1] = rk[1] ^ ref_sbox[rk[14]];
        rk[2] = rk[2] ^ ref_sbox[rk[15]];
        rk[3] = rk[3] ^ ref_sbox[rk[12]];
        for (int i = 4; i < 16; i++)
        begin
            rk[i] = rk[i] ^ rk[i-4];
        end
        rc = gf_double(rc);
        // SubBytes with ShiftRows folded into the source index
        for (int i = 0; i < 16; i++)
        begin
            tmp[i] = ref_sbox[st[(i + 4*(i%4)) % 16]];
        end
        for (int c = 0; c < 4; c++)
        begin
            for (int r = 0; r < 4; r++)
            begin
                if (rnd == 10)
                    st[4*c+r] = tmp[4*c+r]; // no MixColumns in the final round
                else
                    st[4*c+r] = gf_double(tmp[4*c+r]) ^ gf_double(tmp[4*c+(r+1)%4])
                                ^ tmp[4*c+(r+1)%4] ^ tmp[4*c+(r+2)%4] ^ tmp[4*c+(r+3)%4];
                st[4*c+r] = st[4*c+r] ^ rk[4*c+r];
            end
        end
    end
    for (int i = 0; i < 16; i++)
    begin
        ct[127-8*i -: 8] = st[i];
    end
    return ct;
endfunction

`endif

// ==== tb_aes_top.sv ====
/*
 * testbench for the APB AES-128 core, all traffic goes through APB
 * every transfer is setup plus one access cycle since pready is tied high
 * read data is sampled on the falling edge inside the access phase
 */
`timescale 1ns/1ps

module tb_aes_top
    import aes_pkg::*;
();

    `include "tb_aes_model.svh"

    localparam int num_blocks      = 24; // known answer, two latency runs, 20 random, busy
    localparam int watchdog_cycles = (num_blocks * 20 + 200) * 3;

    logic        clk;
    logic        resetn;
    logic [11:0] paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic [31:0] lcg_state;
    int          errors;       // errors of the running test
    int          tests_run;
    int          tests_failed;

    aes_top u_dut (
        .clk     (clk),
        .resetn  (resetn),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial
    begin
        #(watchdog_cycles * 100);
        $display("watchdog expired after %0d cycles, the tests never completed", watchdog_cycles);
        $display("test failed");
        $finish;
    end

    // the slave has no wait states so pready must be high in every access phase
    task automatic check_ready();
        assert (pready === 1'b1)
        else
        begin
            $display("Error at %0t ns: pready expected 1 in the access phase, got %b",
                     $time, pready);
            errors++;
        end
    endtask

    // the write lands on the edge that closes the access phase
    task automatic apb_write(input logic [11:0] addr, input logic [31:0] data);
        @(posedge clk);
        #5;
        psel    = 1'b1;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        penable = 1'b0;
        @(posedge clk);
        #5 penable = 1'b1;
        @(negedge clk);
        check_ready();
        @(posedge clk);
        #5;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_read(input logic [11:0] addr, output logic [31:0] data);
        @(posedge clk);
        #5;
        psel    = 1'b1;
        pwrite  = 1'b0;
        paddr   = addr;
        penable = 1'b0;
        @(posedge clk);
        #5 penable = 1'b1;
        @(negedge clk);
        data = prdata; // stable halfway through the access phase
        check_ready();
        @(posedge clk);
        #5;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic write_block(input logic [11:0] base, input logic [127:0] v);
        for (int i = 0; i < 4; i++)
        begin
            apb_write(base + 12'(4*i), v[127-32*i -: 32]); // word 0 holds bytes 0 to 3
        end
    endtask

    task automatic read_block(input logic [11:0] base, output logic [127:0] v);
        logic [31:0] w;
        for (int i = 0; i < 4; i++)
        begin
            apb_read(base + 12'(4*i), w);
            v[127-32*i -: 32] = w;
        end
    endtask

    task automatic next_block(output logic [127:0] v);
        for (int i = 0; i < 4; i++)
        begin
            lcg_state = lcg_next(lcg_state);
            v[127-32*i -: 32] = lcg_state;
        end
    endtask

    task automatic check_value(input logic [127:0] got, input logic [127:0] exp,
                               input string what);
        assert (got === exp)
        else
        begin
            $display("Error at %0t ns: %s expected %h, got %h", $time, what, exp, got);
            errors++;
        end
    endtask

    task automatic wait_done();
        logic [31:0] status;
        int          polls;
        polls = 0;
        do
        begin
            apb_read(reg_status, status);
            polls++;
        end
        while (!status[1] && polls < 12);
        assert (status[1])
        else
        begin
            $display("the AES core never finished the block after %0d status polls", polls);
            errors++;
        end
    endtask

    // loads one block, starts it and compares DOUT with the model
    task automatic encrypt_and_check(input logic [127:0] k, input logic [127:0] p,
                                     input string what);
        logic [31:0]  status;
        logic [127:0] ct;
        write_block(reg_key0, k);
        write_block(reg_din0, p);
        apb_write(reg_ctrl, 32'h1);
        apb_read(reg_status, status);
        check_value(status, 32'h1, {what, " status after start"}); // busy set, done cleared
        wait_done();
        read_block(reg_dout0, ct);
        check_value(ct, aes128_encrypt(k, p), what);
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors == 0)
            $display("%s: pass", name);
        else
        begin
            tests_failed++;
            $display("%s: FAIL with %0d errors", name, errors);
        end
        errors = 0;
    endtask

    initial
    begin
        logic [31:0]  rdata;
        logic [127:0] k;
        logic [127:0] p;
        logic [127:0] v;
        resetn       = 1'b0;
        paddr        = '0;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        pwdata       = '0;
        lcg_state    = 32'h6df7_eea5;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        repeat (10) @(posedge clk);
        #5 resetn = 1'b1;

        apb_read(reg_status, rdata);
        check_value(rdata, '0, "STATUS after reset");
        read_block(reg_dout0, v);
        check_value(v, '0, "DOUT after reset");
        read_block(reg_key0, v);
        check_value(v, '0, "KEY after reset");
        read_block(reg_din0, v);
        check_value(v, '0, "DIN after reset");
        finish_test("reset state");

        k = 128'h000102030405060708090a0b0c0d0e0f;
        p = 128'h00112233445566778899aabbccddeeff;
        check_value(aes128_encrypt(k, p), 128'h69c4e0d86a7b0430d8cdb78070b4c55a, "model vector");
        encrypt_and_check(k, p, "FIPS-197 vector");
        finish_test("known answer");

        // start write closes at edge T, each read below opens its access at T+n
        apb_write(reg_ctrl, 32'h1);
        apb_read(reg_status, rdata);                  // access at T+2
        check_value(rdata, 32'h1, "STATUS at T+2");
        repeat (6) @(posedge clk);
        apb_read(reg_status, rdata);                  // access at T+11
        check_value(rdata, 32'h1, "STATUS at T+11");
        wait_done();
        apb_write(reg_ctrl, 32'h1);
        repeat (10) @(posedge clk);
        apb_read(reg_status, rdata);                  // access at T+12
        check_value(rdata, 32'h2, "STATUS at T+12");
        read_block(reg_dout0, v);
        check_value(v, 128'h69c4e0d86a7b0430d8cdb78070b4c55a, "DOUT after timed run");
        finish_test("latency and status");

        for (int n = 0; n < 20; n++)
        begin
            next_block(k);
            next_block(p);
            encrypt_and_check(k, p, $sformatf("random block %0d", n));
        end
        finish_test("random blocks");

        next_block(k);
        next_block(p);
        write_block(reg_key0, k);
        write_block(reg_din0, p);
        apb_write(reg_ctrl, 32'h1);                   // accepted start closes at T
        apb_write(reg_key0, ~k[127:96]);              // all three land while busy
        apb_write(reg_din0, ~p[127:96]);
        apb_write(reg_ctrl, 32'h1);                   // closes at T+9
        @(posedge clk);
        apb_read(reg_status, rdata);                  // access at T+12, a restart would be busy
        check_value(rdata, 32'h2, "STATUS 12 cycles after the accepted start");
        read_block(reg_dout0, v);
        check_value(v, aes128_encrypt(k, p), "result with writes while busy");
        read_block(reg_key0, v);
        check_value(v, k, "KEY after writes while busy");
        read_block(reg_din0, v);
        check_value(v, p, "DIN after writes while busy");
        finish_test("busy protection");

        next_block(k);
        next_block(p);
        write_block(reg_key0, k);
        write_block(reg_din0, p);
        read_block(reg_key0, v);
        check_value(v, k, "KEY read back");
        read_block(reg_din0, v);
        check_value(v, p, "DIN read back");
        apb_read(reg_ctrl, rdata);
        check_value(rdata, '0, "CTRL read");
        apb_read(12'h008, rdata);
        check_value(rdata, '0, "unmapped 0x008");
        apb_read(12'h040, rdata);
        check_value(rdata, '0, "unmapped 0x040");
        apb_read(12'hffc, rdata);
        check_value(rdata, '0, "unmapped 0xffc");
        read_block(reg_dout0, p);
        write_block(reg_dout0, ~p);                   // DOUT is read-only
        read_block(reg_dout0, v);
        check_value(v, p, "DOUT after write");
        finish_test("register map");

        $display("%0d tests run, %0d passed, %0d failed",
                 tests_run, tests_run - tests_failed, tests_failed);
        if (tests_failed == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+.
aes_pkg.sv
aes_key_expand.sv
aes_round_func.sv
aes_add_round_key.sv
aes_core.sv
aes_apb_regs.sv
aes_top.sv
tb_aes_top.sv
